/* logic/hbus_pkg.sv */
`default_nettype none

package hbus_pkg;

	// bus phases, walked in this order for every transfer
	typedef enum logic [2:0] {
		IDLE,
		PRE,
		CA,
		LATENCY,
		WRITE,
		READ,
		POST
	} bus_state_e;

	// command-address word, shifted out msb byte first
	typedef struct packed {
		// 1 = read, 0 = write
		logic        rd;
		// 1 = register space, 0 = memory space
		logic        reg_space;
		// burst type, always linear here
		logic        linear;
		logic [28:0] addr_hi;
		logic [12:0] reserved;
		logic [2:0]  addr_lo;
	} ca_word_t;

	// everything the controller drives onto the bus
	typedef struct packed {
		logic       rstn;
		logic       csn;
		logic       clk;
		logic       clkn;
		logic       rwds;
		// output enables are active low
		logic       rwds_oen;
		logic [7:0] dq;
		logic       dq_oen;
	} hbus_out_t;

	// what the device can drive back
	typedef struct packed {
		logic       rwds;
		logic [7:0] dq;
	} hbus_in_t;

	// bytes moved per phase
	localparam int CA_BYTES = 6;
	localparam int MEM_BYTES = 4;
	localparam int REG_BYTES = 2;

	// phase counter width, enough for the longest latency or timeout
	localparam int CNT_W = 6;

	// lower bounds the timing parameters are clamped to
	localparam int MIN_TACC = 2;
	localparam int MIN_TRMAX = 4;

endpackage

`default_nettype wire

/* logic/host_pkg.sv */
`default_nettype none

package host_pkg;

	// one host request, sampled on the rising edge of valid
	typedef struct packed {
		// 1 = write, 0 = read
		logic        wren;
		// 1 = register space, 0 = memory space
		logic        regspace;
		logic [31:0] addr;
		// byte enables for memory writes, bit 3 is the msb byte
		logic [3:0]  sel;
		logic [31:0] data;
	} host_req_t;

	// answer to the host, valid once ready rises again
	typedef struct packed {
		// memory reads fill all four bytes, register reads only 15:0
		logic [31:0] data;
		// device never strobed the expected bytes
		logic        read_timeout;
	} host_rsp_t;

endpackage

`default_nettype wire

/* logic/hbus_seq_fsm.sv */
`default_nettype none

module hbus_seq_fsm (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  valid_i,
	input  host_pkg::host_req_t   req_i,
	input  logic                  timer_done_i,
	input  logic                  read_done_i,
	output logic                  ready_o,
	output hbus_pkg::bus_state_e  state_o,
	output logic                  load_o,
	output hbus_pkg::ca_word_t    ca_o,
	output logic [31:0]           wdata_o,
	output logic [3:0]            sel_o,
	output logic                  read_timeout_o
);

	hbus_pkg::bus_state_e state_r;
	hbus_pkg::bus_state_e state_nxt;
	logic valid_r;
	logic valid_start;
	logic accept;
	logic busy_r;
	logic load_r;
	logic timeout_r;
	hbus_pkg::ca_word_t ca_r;
	logic [31:0] wdata_r;
	logic [3:0] sel_r;

	// host must drop valid between requests, only a rising edge starts one
	assign valid_start = valid_i & ~valid_r;
	assign accept = valid_start & ~busy_r;

	always_comb begin
		state_nxt = state_r;
		case (state_r)
			hbus_pkg::IDLE: begin
				// wait out cs high time, then start the accepted or pending request
				if (timer_done_i && (busy_r || accept)) begin
					state_nxt = hbus_pkg::PRE;
				end
			end
			hbus_pkg::PRE: begin
				if (timer_done_i) begin
					state_nxt = hbus_pkg::CA;
				end
			end
			hbus_pkg::CA: begin
				if (timer_done_i) begin
					// register writes carry no latency
					if (!ca_r.rd && ca_r.reg_space) begin
						state_nxt = hbus_pkg::WRITE;
					end else begin
						state_nxt = hbus_pkg::LATENCY;
					end
				end
			end
			hbus_pkg::LATENCY: begin
				if (timer_done_i) begin
					state_nxt = ca_r.rd ? hbus_pkg::READ : hbus_pkg::WRITE;
				end
			end
			hbus_pkg::WRITE: begin
				if (timer_done_i) begin
					state_nxt = hbus_pkg::POST;
				end
			end
			hbus_pkg::READ: begin
				// all bytes in, or device stayed silent too long
				if (read_done_i || timer_done_i) begin
					state_nxt = hbus_pkg::POST;
				end
			end
			hbus_pkg::POST: begin
				if (timer_done_i) begin
					state_nxt = hbus_pkg::IDLE;
				end
			end
			default: state_nxt = hbus_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_r <= hbus_pkg::IDLE;
			valid_r <= 1'b0;
			busy_r <= 1'b0;
			load_r <= 1'b0;
			timeout_r <= 1'b0;
		end else begin
			valid_r <= valid_i;
			state_r <= state_nxt;
			// strobe in the first cycle of every new phase
			load_r <= (state_nxt != state_r);
			if (accept) begin
				busy_r <= 1'b1;
				timeout_r <= 1'b0;
			end else if ((state_r == hbus_pkg::POST) && (state_nxt == hbus_pkg::IDLE)) begin
				busy_r <= 1'b0;
			end
			// a finished byte count wins over a timer expiring in the same cycle
			if ((state_r == hbus_pkg::READ) && (state_nxt == hbus_pkg::POST)) begin
				timeout_r <= ~read_done_i;
			end
		end
	end

	// request payload, held for the whole transfer
	always_ff @(posedge clk_i) begin
		if (accept) begin
			ca_r.rd <= ~req_i.wren;
			ca_r.reg_space <= req_i.regspace;
			ca_r.linear <= 1'b1;
			ca_r.addr_hi <= req_i.addr[31:3];
			ca_r.reserved <= '0;
			ca_r.addr_lo <= req_i.addr[2:0];
			wdata_r <= req_i.data;
			sel_r <= req_i.sel;
		end
	end

	assign ready_o = ~busy_r;
	assign state_o = state_r;
	assign load_o = load_r;
	assign ca_o = ca_r;
	assign wdata_o = wdata_r;
	assign sel_o = sel_r;
	assign read_timeout_o = timeout_r;

endmodule

`default_nettype wire

/* logic/hbus_phase_timer.sv */
`default_nettype none

module hbus_phase_timer #(
	parameter int unsigned TCSH = 4,
	parameter int unsigned TPRE = 4,
	parameter int unsigned TACC = 6,
	parameter int unsigned TPOST = 4,
	parameter int unsigned TRMAX = 20
) (
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  logic                        load_i,
	input  hbus_pkg::bus_state_e        state_i,
	input  hbus_pkg::ca_word_t          ca_i,
	input  logic                        rwds_2x_i,
	output logic [hbus_pkg::CNT_W-1:0]  count_o,
	output logic                        done_o
);

	localparam int CW = hbus_pkg::CNT_W;
	// clamp to what the device can actually do
	localparam int TACC_C = (TACC >= hbus_pkg::MIN_TACC) ? TACC : hbus_pkg::MIN_TACC;
	localparam int TRMAX_C = (TRMAX >= hbus_pkg::MIN_TRMAX) ? TRMAX : hbus_pkg::MIN_TRMAX;
	// one bus byte per cycle, so a bus clock is two cycles
	localparam logic [CW-1:0] LAT_1X = CW'(2 * TACC_C);
	localparam logic [CW-1:0] LAT_2X = CW'(4 * TACC_C);

	logic [CW-1:0] cnt_r;
	logic [CW-1:0] len;

	// load value is phase length minus one, the count ends at zero
	always_comb begin
		case (state_i)
			hbus_pkg::IDLE: len = CW'(TCSH);
			hbus_pkg::PRE: len = CW'(TPRE);
			hbus_pkg::CA: len = CW'(hbus_pkg::CA_BYTES - 1);
			hbus_pkg::LATENCY: begin
				// reads need one cycle more for the delayed data strobe
				len = (rwds_2x_i ? LAT_2X : LAT_1X) - (ca_i.rd ? CW'(2) : CW'(3));
			end
			hbus_pkg::WRITE: begin
				len = ca_i.reg_space ? CW'(hbus_pkg::REG_BYTES - 1) : CW'(hbus_pkg::MEM_BYTES - 1);
			end
			hbus_pkg::READ: len = CW'(2 * TRMAX_C - 2);
			hbus_pkg::POST: len = CW'(TPOST);
			default: len = '0;
		endcase
	end

	// first cycle of a phase already shows the loaded value
	assign count_o = load_i ? len : cnt_r;
	assign done_o = (count_o == '0);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			// cs high time also applies right after reset
			cnt_r <= CW'(TCSH);
		end else if (done_o) begin
			// stay at zero, idle keeps reporting done
			cnt_r <= '0;
		end else begin
			cnt_r <= count_o - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* logic/hbus_tx_path.sv */
`default_nettype none

module hbus_tx_path (
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  hbus_pkg::bus_state_e        state_i,
	input  hbus_pkg::ca_word_t          ca_i,
	input  logic [31:0]                 wdata_i,
	input  logic [3:0]                  sel_i,
	input  logic [hbus_pkg::CNT_W-1:0]  count_i,
	input  logic                        read_tail_i,
	output hbus_pkg::hbus_out_t         bus_o
);

	logic [47:0] ca_bits;
	logic bus_clk_r;
	logic clk_active;
	logic mem_write;
	logic [1:0] wr_idx;
	logic [7:0] dq_byte;

	assign ca_bits = ca_i;

	// last bus clock of a read is not needed, so stop once fewer than two bytes remain
	assign clk_active = (state_i == hbus_pkg::CA) || (state_i == hbus_pkg::LATENCY) ||
		(state_i == hbus_pkg::WRITE) || ((state_i == hbus_pkg::READ) && !read_tail_i);

	assign mem_write = (state_i == hbus_pkg::WRITE) && !ca_i.reg_space;

	// register writes send the upper half, count runs 1..0 there
	assign wr_idx = count_i[1:0] + (ca_i.reg_space ? 2'd2 : 2'd0);

	// bus clock toggles once per cycle while active, parks low otherwise
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			bus_clk_r <= 1'b0;
		end else if (clk_active) begin
			bus_clk_r <= ~bus_clk_r;
		end else begin
			bus_clk_r <= 1'b0;
		end
	end

	// byte select, msb first as the count runs down
	always_comb begin
		case (state_i)
			hbus_pkg::CA: begin
				case (count_i)
					6'd5: dq_byte = ca_bits[47:40];
					6'd4: dq_byte = ca_bits[39:32];
					6'd3: dq_byte = ca_bits[31:24];
					6'd2: dq_byte = ca_bits[23:16];
					6'd1: dq_byte = ca_bits[15:8];
					6'd0: dq_byte = ca_bits[7:0];
					default: dq_byte = 8'h00;
				endcase
			end
			hbus_pkg::WRITE: dq_byte = wdata_i[8*wr_idx +: 8];
			default: dq_byte = 8'h00;
		endcase
	end

	always_comb begin
		bus_o.rstn = ~rst_i;
		// chip stays selected from PRE through POST
		bus_o.csn = (state_i == hbus_pkg::IDLE);
		bus_o.clk = bus_clk_r;
		bus_o.clkn = ~bus_clk_r;
		// rwds is the write mask, high masks the byte
		bus_o.rwds = mem_write ? ~sel_i[count_i[1:0]] : 1'b0;
		// register writes leave rwds to the device
		bus_o.rwds_oen = ~mem_write;
		bus_o.dq = dq_byte;
		bus_o.dq_oen = !((state_i == hbus_pkg::CA) || (state_i == hbus_pkg::WRITE));
	end

endmodule

`default_nettype wire

/* logic/hbus_rx_capture.sv */
`default_nettype none

module hbus_rx_capture (
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  hbus_pkg::bus_state_e        state_i,
	input  hbus_pkg::ca_word_t          ca_i,
	input  logic [hbus_pkg::CNT_W-1:0]  count_i,
	input  hbus_pkg::hbus_in_t          bus_i,
	output logic                        rwds_2x_o,
	output logic                        read_done_o,
	output logic                        read_tail_o,
	output logic [31:0]                 data_o
);

	logic rwds_prev_r;
	logic rwds_2x_r;
	logic [2:0] rd_cnt_r;
	logic [31:0] data_r;
	logic take;

	// first byte of a pair comes with rwds high, the second one a cycle later
	assign take = (rd_cnt_r != 3'd0) &&
		((!rd_cnt_r[0] && bus_i.rwds) || (rd_cnt_r[0] && rwds_prev_r));

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rwds_prev_r <= 1'b0;
			// device powers up with double latency
			rwds_2x_r <= 1'b1;
			rd_cnt_r <= 3'd0;
			data_r <= '0;
		end else begin
			rwds_prev_r <= bus_i.rwds;
			case (state_i)
				hbus_pkg::PRE: data_r <= '0;
				hbus_pkg::CA: begin
					// device flags its latency on rwds mid CA
					if (count_i == 6'd2) begin
						rwds_2x_r <= bus_i.rwds;
						rd_cnt_r <= ca_i.reg_space ? 3'(hbus_pkg::REG_BYTES) :
							3'(hbus_pkg::MEM_BYTES);
					end
				end
				hbus_pkg::READ: begin
					if (take) begin
						rd_cnt_r <= rd_cnt_r - 3'd1;
						case (rd_cnt_r)
							3'd4: data_r[31:24] <= bus_i.dq;
							3'd3: data_r[23:16] <= bus_i.dq;
							3'd2: data_r[15:8] <= bus_i.dq;
							default: data_r[7:0] <= bus_i.dq;
						endcase
					end
				end
				default: ;
			endcase
		end
	end

	assign rwds_2x_o = rwds_2x_r;
	assign read_done_o = (rd_cnt_r == 3'd0);
	assign read_tail_o = (rd_cnt_r < 3'd2);
	assign data_o = data_r;

endmodule

`default_nettype wire

/* logic/hram_ctrl.sv */
`default_nettype none

module hram_ctrl #(
	// cs high time between transfers
	parameter int unsigned TCSH = 4,
	// cs fall to first bus clock edge
	parameter int unsigned TPRE = 4,
	// initial access latency in bus clocks
	parameter int unsigned TACC = 6,
	// last bus clock edge to cs rise
	parameter int unsigned TPOST = 4,
	// read timeout in bus clocks
	parameter int unsigned TRMAX = 20
) (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 valid_i,
	input  host_pkg::host_req_t  req_i,
	output logic                 ready_o,
	output host_pkg::host_rsp_t  rsp_o,
	output hbus_pkg::hbus_out_t  bus_o,
	input  hbus_pkg::hbus_in_t   bus_i
);

	// sequencer outputs
	hbus_pkg::bus_state_e state;
	logic load;
	hbus_pkg::ca_word_t ca;
	logic [31:0] wdata;
	logic [3:0] sel;
	logic read_timeout;

	// timer outputs
	logic [hbus_pkg::CNT_W-1:0] count;
	logic timer_done;

	// capture outputs
	logic rwds_2x;
	logic read_done;
	logic read_tail;
	logic [31:0] rdata;

	hbus_seq_fsm i_seq_fsm (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.valid_i        (valid_i),
		.req_i          (req_i),
		.timer_done_i   (timer_done),
		.read_done_i    (read_done),
		.ready_o        (ready_o),
		.state_o        (state),
		.load_o         (load),
		.ca_o           (ca),
		.wdata_o        (wdata),
		.sel_o          (sel),
		.read_timeout_o (read_timeout)
	);

	// only the timer needs the timing parameters
	hbus_phase_timer #(
		.TCSH  (TCSH),
		.TPRE  (TPRE),
		.TACC  (TACC),
		.TPOST (TPOST),
		.TRMAX (TRMAX)
	) i_phase_timer (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.load_i    (load),
		.state_i   (state),
		.ca_i      (ca),
		.rwds_2x_i (rwds_2x),
		.count_o   (count),
		.done_o    (timer_done)
	);

	hbus_tx_path i_tx_path (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.state_i     (state),
		.ca_i        (ca),
		.wdata_i     (wdata),
		.sel_i       (sel),
		.count_i     (count),
		.read_tail_i (read_tail),
		.bus_o       (bus_o)
	);

	hbus_rx_capture i_rx_capture (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.state_i     (state),
		.ca_i        (ca),
		.count_i     (count),
		.bus_i       (bus_i),
		.rwds_2x_o   (rwds_2x),
		.read_done_o (read_done),
		.read_tail_o (read_tail),
		.data_o      (rdata)
	);

	assign rsp_o = '{data: rdata, read_timeout: read_timeout};

endmodule

`default_nettype wire

/* dv/hram_dev_model.sv */
`default_nettype none

module hram_dev_model #(
	// initial access latency in bus clocks, must match the controller
	parameter int unsigned TACC = 6
) (
	input  logic                 clk_i,
	input  hbus_pkg::hbus_out_t  bus_i,
	output hbus_pkg::hbus_in_t   bus_o,
	// device behavior for the next transfer
	input  logic                 lat2x_i,
	input  logic                 silent_i,
	input  logic [31:0]          rdata_i,
	// log of the last transfer
	output logic [47:0]          ca_o,
	output logic [31:0]          wdata_o,
	output logic [3:0]           wmask_o,
	output int                   wbytes_o,
	output int                   lat_o,
	output logic                 rwds_drv_o
);

	logic active;
	// bytes the controller drove in this transfer, ca included
	int nbytes;
	// cycles since the last ca byte
	int gap;
	int rlat;
	int idx;

	initial begin
		bus_o = '0;
		active = 1'b0;
		nbytes = 0;
		gap = 0;
		ca_o = '0;
		wdata_o = '0;
		wmask_o = '0;
		wbytes_o = 0;
		lat_o = 0;
		rwds_drv_o = 1'b0;
	end

	// sample mid cycle, answer for the rest of the same cycle
	always @(negedge clk_i) begin
		bus_o = '0;
		if (bus_i.csn === 1'b0) begin
			// new transfer, forget the previous one
			if (!active) begin
				active = 1'b1;
				nbytes = 0;
				gap = 0;
				ca_o = '0;
				wdata_o = '0;
				wmask_o = '0;
				wbytes_o = 0;
				lat_o = -1;
				rwds_drv_o = 1'b0;
			end
			if (nbytes >= hbus_pkg::CA_BYTES) begin
				gap++;
			end
			if (!bus_i.rwds_oen) begin
				rwds_drv_o = 1'b1;
			end
			if (!bus_i.dq_oen) begin
				if (nbytes < hbus_pkg::CA_BYTES) begin
					ca_o = {ca_o[39:0], bus_i.dq};
					// latency flag shown during the whole ca phase
					bus_o.rwds = lat2x_i;
				end else begin
					if (wbytes_o == 0) begin
						lat_o = gap - 1;
					end
					wdata_o = {wdata_o[23:0], bus_i.dq};
					// controller rwds during a write is the byte mask
					wmask_o = {wmask_o[2:0], bus_i.rwds};
					wbytes_o++;
				end
				nbytes++;
			end else if ((nbytes >= hbus_pkg::CA_BYTES) && ca_o[47] && !silent_i) begin
				// read data starts right after the read latency
				rlat = 2 * TACC * (lat2x_i ? 2 : 1) - 1;
				idx = gap - rlat - 1;
				// register reads return two bytes, memory reads four
				if ((idx >= 0) && (idx < (ca_o[46] ? 2 : 4))) begin
					bus_o.dq = rdata_i[31 - 8*idx -: 8];
					// strobe high on the first byte of each pair
					bus_o.rwds = ((idx % 2) == 0);
				end
			end
		end else begin
			active = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* dv/hram_ctrl_tb.sv */
`default_nettype none

module hram_ctrl_tb;

	localparam int TCSH = 2;
	localparam int TPRE = 1;
	localparam int TACC = 3;
	localparam int TPOST = 1;
	localparam int TRMAX = 6;
	localparam int PERIOD = 100;
	localparam int RESET_CYC = 4;
	localparam int N_TESTS = 8;
	// generous bound for the longest transfer, a silent double latency read
	localparam int MAX_XFER_CYC = 64;
	localparam int WATCHDOG_CYC = RESET_CYC + 4 + N_TESTS * (MAX_XFER_CYC + 8);

	// one row of the stimulus table
	typedef struct packed {
		logic        wr;
		logic        rs;
		logic [3:0]  sel;
		logic        lat2x;
		logic        silent;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp_data;
		logic        exp_to;
	} entry_t;

	logic clk_i = 1'b0;
	logic rst_i;
	logic valid;
	host_pkg::host_req_t req;
	logic ready;
	host_pkg::host_rsp_t rsp;
	hbus_pkg::hbus_out_t bus_out;
	hbus_pkg::hbus_in_t bus_in;

	// device model control and log
	logic dev_lat2x;
	logic dev_silent;
	logic [31:0] dev_rdata;
	logic [47:0] dev_ca;
	logic [31:0] dev_wdata;
	logic [3:0] dev_wmask;
	int dev_wbytes;
	int dev_lat;
	logic dev_rwds_drv;

	entry_t tbl [N_TESTS];
	logic [31:0] lcg_state;
	int err_cnt;
	int fail_cnt;
	int xfer_cnt;
	int csn_high_run;
	logic test_bad;

	hram_ctrl #(
		.TCSH  (TCSH),
		.TPRE  (TPRE),
		.TACC  (TACC),
		.TPOST (TPOST),
		.TRMAX (TRMAX)
	) i_hram_ctrl (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.valid_i (valid),
		.req_i   (req),
		.ready_o (ready),
		.rsp_o   (rsp),
		.bus_o   (bus_out),
		.bus_i   (bus_in)
	);

	hram_dev_model #(
		.TACC (TACC)
	) i_dev_model (
		.clk_i      (clk_i),
		.bus_i      (bus_out),
		.bus_o      (bus_in),
		.lat2x_i    (dev_lat2x),
		.silent_i   (dev_silent),
		.rdata_i    (dev_rdata),
		.ca_o       (dev_ca),
		.wdata_o    (dev_wdata),
		.wmask_o    (dev_wmask),
		.wbytes_o   (dev_wbytes),
		.lat_o      (dev_lat),
		.rwds_drv_o (dev_rwds_drv)
	);

	initial begin
		forever #(PERIOD / 2) clk_i = ~clk_i;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// read flag, space flag, linear burst, upper address, reserved, lower address
	function automatic logic [47:0] expect_ca(input logic rd, input logic rs,
		input logic [31:0] addr);
		return {rd, rs, 1'b1, addr[31:3], 13'h0, addr[2:0]};
	endfunction

	function automatic string op_name(input entry_t e);
		if (e.wr && e.rs) begin
			return "register write";
		end else if (e.wr) begin
			return "memory write";
		end else if (e.rs) begin
			return "register read";
		end
		return "memory read";
	endfunction

	// address and data from the lcg, expected response from the read rules
	task automatic add_entry(input int i, input logic wr, input logic rs,
		input logic [3:0] sel, input logic lat2x, input logic silent);
		entry_t e;
		e = '0;
		e.wr = wr;
		e.rs = rs;
		e.sel = sel;
		e.lat2x = lat2x;
		e.silent = silent;
		lcg_state = lcg_next(lcg_state);
		e.addr = lcg_state;
		lcg_state = lcg_next(lcg_state);
		e.data = lcg_state;
		// register reads land in the low half, a silent device leaves zeros
		if (!wr && !silent) begin
			e.exp_data = rs ? {16'h0, e.data[31:16]} : e.data;
		end
		e.exp_to = !wr && silent;
		tbl[i] = e;
	endtask

	task automatic compare_value(input string sig, input logic [47:0] got,
		input logic [47:0] exp);
		assert (got === exp) else begin
			$display("Fail at %0t: %s is %h, expected %h", $time, sig, got, exp);
			err_cnt++;
			test_bad = 1'b1;
		end
	endtask

	// csn spacing, transfer count, parked bus clock and ready during a transfer
	always @(negedge clk_i) begin
		if (rst_i !== 1'b0) begin
			csn_high_run = 0;
		end else if (bus_out.csn) begin
			csn_high_run++;
			// bus clock rests low outside a transfer
			assert (!bus_out.clk && bus_out.clkn) else begin
				$display("%0t: bus clock is not parked low while csn is high", $time);
				err_cnt++;
				test_bad = 1'b1;
			end
		end else begin
			if (csn_high_run > 0) begin
				// spacing applies between two transfers, not after reset
				assert ((xfer_cnt == 0) || (csn_high_run >= TCSH + 1)) else begin
					$display("%0t: csn was high for only %0d cycles before a transfer",
						$time, csn_high_run);
					err_cnt++;
					test_bad = 1'b1;
				end
				xfer_cnt++;
			end
			csn_high_run = 0;
			assert (!ready) else begin
				$display("%0t: ready_o is high while csn is low", $time);
				err_cnt++;
				test_bad = 1'b1;
			end
		end
	end

	initial begin
		#(WATCHDOG_CYC * PERIOD);
		$display("watchdog expired before all tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		entry_t e;
		int wait_cyc;
		int exp_lat;
		rst_i = 1'b1;
		valid = 1'b0;
		req = '0;
		dev_lat2x = 1'b0;
		dev_silent = 1'b0;
		dev_rdata = '0;
		err_cnt = 0;
		fail_cnt = 0;
		xfer_cnt = 0;
		csn_high_run = 0;
		test_bad = 1'b0;
		lcg_state = 32'd86207;
		add_entry(0, 1'b1, 1'b0, 4'b1111, 1'b1, 1'b0);
		add_entry(1, 1'b1, 1'b0, 4'b1010, 1'b0, 1'b0);
		add_entry(2, 1'b1, 1'b1, 4'b1111, 1'b1, 1'b0);
		add_entry(3, 1'b0, 1'b0, 4'b1111, 1'b1, 1'b0);
		add_entry(4, 1'b0, 1'b1, 4'b1111, 1'b0, 1'b0);
		// silent device, then a good read that must clear the flag
		add_entry(5, 1'b0, 1'b0, 4'b1111, 1'b0, 1'b1);
		add_entry(6, 1'b0, 1'b0, 4'b1111, 1'b1, 1'b0);
		add_entry(7, 1'b1, 1'b0, 4'b0110, 1'b0, 1'b0);
		repeat (RESET_CYC) @(negedge clk_i);
		// outputs while reset is still held
		compare_value("ready_o", ready, 1'b1);
		compare_value("bus_o.csn", bus_out.csn, 1'b1);
		compare_value("bus_o.clk", bus_out.clk, 1'b0);
		compare_value("bus_o.dq_oen", bus_out.dq_oen, 1'b1);
		compare_value("bus_o.rwds_oen", bus_out.rwds_oen, 1'b1);
		compare_value("bus_o.rstn", bus_out.rstn, 1'b0);
		compare_value("rsp_o", rsp, '0);
		rst_i = 1'b0;
		repeat (2) @(negedge clk_i);
		for (int i = 0; i < N_TESTS; i++) begin
			e = tbl[i];
			test_bad = 1'b0;
			dev_lat2x = e.lat2x;
			dev_silent = e.silent;
			dev_rdata = e.data;
			req = '{wren: e.wr, regspace: e.rs, addr: e.addr, sel: e.sel, data: e.data};
			valid = 1'b1;
			@(negedge clk_i);
			assert (!ready) else begin
				$display("%0t: ready_o did not fall after test %0d was sent", $time, i);
				err_cnt++;
				test_bad = 1'b1;
			end
			wait_cyc = 0;
			while (!ready && (wait_cyc < MAX_XFER_CYC)) begin
				@(negedge clk_i);
				wait_cyc++;
			end
			assert (ready) else begin
				$display("%0t: ready_o stayed low for %0d cycles in test %0d",
					$time, MAX_XFER_CYC, i);
				err_cnt++;
				test_bad = 1'b1;
			end
			if ((i % 2) == 0) begin
				// valid still high, the controller must not start again
				repeat (2) begin
					@(negedge clk_i);
					compare_value("ready_o", ready, 1'b1);
				end
				valid = 1'b0;
			end else begin
				// next request arrives while the cs high time is still running
				valid = 1'b0;
			end
			@(negedge clk_i);
			assert (xfer_cnt == i + 1) else begin
				$display("%0t: test %0d saw %0d transfers in total instead of %0d",
					$time, i, xfer_cnt, i + 1);
				err_cnt++;
				test_bad = 1'b1;
			end
			compare_value("bus_o.rstn", bus_out.rstn, 1'b1);
			compare_value("ca bytes", dev_ca, expect_ca(!e.wr, e.rs, e.addr));
			if (e.wr && e.rs) begin
				compare_value("dq write data", dev_wdata, {16'h0, e.data[31:16]});
				compare_value("write byte count", dev_wbytes, 2);
				compare_value("latency cycles", dev_lat, 0);
				compare_value("rwds_oen active", dev_rwds_drv, 1'b0);
			end else if (e.wr) begin
				exp_lat = 2 * TACC * (e.lat2x ? 2 : 1) - 2;
				compare_value("dq write data", dev_wdata, e.data);
				compare_value("rwds mask", dev_wmask, 4'(~e.sel));
				compare_value("write byte count", dev_wbytes, 4);
				compare_value("latency cycles", dev_lat, exp_lat);
			end else begin
				compare_value("rsp_o.data", rsp.data, e.exp_data);
				compare_value("write byte count", dev_wbytes, 0);
			end
			compare_value("rsp_o.read_timeout", rsp.read_timeout, e.exp_to);
			if (test_bad) begin
				fail_cnt++;
				$display("test %0d %s: failed", i, op_name(e));
			end else begin
				$display("test %0d %s: ok", i, op_name(e));
			end
		end
		$display("%0d tests, %0d failed, %0d check errors", N_TESTS, fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hram_ctrl.f */
logic/hbus_pkg.sv
logic/host_pkg.sv
logic/hbus_seq_fsm.sv
logic/hbus_phase_timer.sv
logic/hbus_tx_path.sv
logic/hbus_rx_capture.sv
logic/hram_ctrl.sv
dv/hram_dev_model.sv
dv/hram_ctrl_tb.sv

/* Bender.yml */
package:
  name: hram_ctrl

sources:
  - logic/hbus_pkg.sv
  - logic/host_pkg.sv
  - logic/hbus_seq_fsm.sv
  - logic/hbus_phase_timer.sv
  - logic/hbus_tx_path.sv
  - logic/hbus_rx_capture.sv
  - logic/hram_ctrl.sv
  - target: test
    files:
      - dv/hram_dev_model.sv
      - dv/hram_ctrl_tb.sv
